//--- hdl/csr_pkg.sv
/*
 * Shared types, CSR addresses, write masks and reset values
 * for the machine-mode CSR bank
 */
`default_nettype none

package csr_pkg;

    typedef logic [31:0] xlen_t;        // CSR data, pc and instruction words
    typedef logic [11:0] csr_addr_t;

    //////////////////////////////////////////////////////////////////////
    // CSR addresses
    //////////////////////////////////////////////////////////////////////

    localparam csr_addr_t ADDR_MSTATUS   = 12'h300;
    localparam csr_addr_t ADDR_MISA      = 12'h301;
    localparam csr_addr_t ADDR_MIE       = 12'h304;
    localparam csr_addr_t ADDR_MTVEC     = 12'h305;
    localparam csr_addr_t ADDR_MSCRATCH  = 12'h340;
    localparam csr_addr_t ADDR_MEPC      = 12'h341;
    localparam csr_addr_t ADDR_MCAUSE    = 12'h342;
    localparam csr_addr_t ADDR_MTVAL     = 12'h343;
    localparam csr_addr_t ADDR_MIP       = 12'h344;
    localparam csr_addr_t ADDR_MCYCLE    = 12'hB00;
    localparam csr_addr_t ADDR_MINSTRET  = 12'hB02;
    localparam csr_addr_t ADDR_MCYCLEH   = 12'hB80;
    localparam csr_addr_t ADDR_MINSTRETH = 12'hB82;
    localparam csr_addr_t ADDR_CYCLE     = 12'hC00;     // User shadows, read only
    localparam csr_addr_t ADDR_INSTRET   = 12'hC02;
    localparam csr_addr_t ADDR_CYCLEH    = 12'hC80;
    localparam csr_addr_t ADDR_INSTRETH  = 12'hC82;
    localparam csr_addr_t ADDR_MVENDORID = 12'hF11;     // ID registers read as zero
    localparam csr_addr_t ADDR_MARCHID   = 12'hF12;
    localparam csr_addr_t ADDR_MIMPID    = 12'hF13;
    localparam csr_addr_t ADDR_MHARTID   = 12'hF14;

    //////////////////////////////////////////////////////////////////////
    // Write masks, constants and reset values
    //////////////////////////////////////////////////////////////////////

    localparam xlen_t MASK_MSTATUS = 32'h007E_19AA;
    localparam xlen_t MASK_MIE     = 32'h0000_0888;    // MEIE, MTIE, MSIE only
    localparam xlen_t MASK_MTVEC   = 32'hFFFF_FFFC;
    localparam xlen_t MASK_MEPC    = 32'hFFFF_FFFC;
    localparam xlen_t MASK_FULL    = 32'hFFFF_FFFF;
    localparam xlen_t MASK_NONE    = 32'h0000_0000;

    // MXL = 1 (32 bit), U, M and I
    localparam xlen_t MISA_VALUE   = 32'h4010_1100;

    localparam xlen_t MSTATUS_RESET = 32'h0000_0000;
    localparam xlen_t MTVEC_RESET   = 32'h0000_0000;

    localparam int MSTATUS_MIE_BIT  = 3;
    localparam int MSTATUS_MPIE_BIT = 7;
    localparam int MSTATUS_MPP_LO   = 11;              // MPP is bits 12:11

    localparam int MEI_BIT = 11;
    localparam int MTI_BIT = 7;
    localparam int MSI_BIT = 3;

    //////////////////////////////////////////////////////////////////////
    // Enums and structs
    //////////////////////////////////////////////////////////////////////

    typedef enum logic [1:0] {
        CSR_WRITE = 2'b01,
        CSR_SET   = 2'b10,
        CSR_CLEAR = 2'b11
    } csr_op_e;

    typedef enum logic [1:0] {
        PRIV_U = 2'b00,
        PRIV_M = 2'b11
    } priv_e;

    typedef enum logic [4:0] {
        EXC_ILLEGAL_INSTR = 5'd2,
        EXC_BREAKPOINT    = 5'd3,
        EXC_ECALL_M       = 5'd11
    } exc_code_e;

    typedef enum logic [4:0] {
        IRQ_M_SW  = 5'd3,
        IRQ_M_TIM = 5'd7,
        IRQ_M_EXT = 5'd11
    } irq_code_e;

    typedef struct packed {
        logic      read_en;
        logic      write_en;
        csr_op_e   op;
        csr_addr_t addr;
        xlen_t     wdata;
    } csr_req_t;

    typedef struct packed {
        logic      raise_exception;
        logic      machine_return;
        exc_code_e exc_code;
        xlen_t     pc;
        xlen_t     instruction;
        logic      jump;
        xlen_t     jump_target;
    } trap_req_t;

    typedef struct packed {
        logic mstatus;
        logic mepc;
        logic mcause;
        logic mtval;
        logic mcycle_lo;
        logic mcycle_hi;
        logic minstret_lo;
        logic minstret_hi;
    } csr_wsel_t;

    typedef struct packed {
        xlen_t mstatus;
        xlen_t mepc;
        xlen_t mcause;
        xlen_t mtval;
    } trap_state_t;

endpackage

`default_nettype wire

//--- hdl/csr_access.sv
/*
 * CSR access unit: address decode, write masks, write/set/clear
 * datapath, read multiplexer, and the mscratch, mtvec, mie registers
 */
`default_nettype none

module csr_access
    import csr_pkg::*;
(
    input  logic        clk,
    input  logic        reset,
    input  csr_req_t    csr_req_i,
    input  logic        killed_i,
    input  trap_state_t trap_state_i,
    input  xlen_t       mip_i,
    input  logic [63:0] mcycle_i,
    input  logic [63:0] minstret_i,
    output xlen_t       wr_data_o,
    output csr_wsel_t   wsel_o,
    output xlen_t       mie_o,
    output xlen_t       mtvec_o,
    output xlen_t       rdata_o
);

    xlen_t mscratch_q;
    xlen_t mtvec_q;
    xlen_t mie_q;
    xlen_t cur_val;
    xlen_t wmask;
    logic  read_ok;
    logic  write_ok;

    assign read_ok  = csr_req_i.read_en & ~killed_i;    // Killed access does nothing
    assign write_ok = csr_req_i.write_en & ~killed_i;

    //////////////////////////////////////////////////////////////////////
    // Current value, also the read multiplexer
    //////////////////////////////////////////////////////////////////////

    always_comb begin
        case (csr_req_i.addr)
            ADDR_MSTATUS:                 cur_val = trap_state_i.mstatus;
            ADDR_MISA:                    cur_val = MISA_VALUE;
            ADDR_MIE:                     cur_val = mie_q;
            ADDR_MTVEC:                   cur_val = mtvec_q;
            ADDR_MSCRATCH:                cur_val = mscratch_q;
            ADDR_MEPC:                    cur_val = trap_state_i.mepc;
            ADDR_MCAUSE:                  cur_val = trap_state_i.mcause;
            ADDR_MTVAL:                   cur_val = trap_state_i.mtval;
            ADDR_MIP:                     cur_val = mip_i;
            ADDR_MCYCLE, ADDR_CYCLE:      cur_val = mcycle_i[31:0];
            ADDR_MCYCLEH, ADDR_CYCLEH:    cur_val = mcycle_i[63:32];
            ADDR_MINSTRET, ADDR_INSTRET:  cur_val = minstret_i[31:0];
            ADDR_MINSTRETH, ADDR_INSTRETH: cur_val = minstret_i[63:32];
            ADDR_MVENDORID, ADDR_MARCHID,
            ADDR_MIMPID, ADDR_MHARTID:    cur_val = '0;
            default:                      cur_val = '0;
        endcase
    end

    assign rdata_o = read_ok ? cur_val : '0;

    // Read-only registers fall to MASK_NONE
    always_comb begin
        case (csr_req_i.addr)
            ADDR_MSTATUS: wmask = MASK_MSTATUS;
            ADDR_MIE:     wmask = MASK_MIE;
            ADDR_MTVEC:   wmask = MASK_MTVEC;
            ADDR_MEPC:    wmask = MASK_MEPC;
            ADDR_MSCRATCH, ADDR_MCAUSE, ADDR_MTVAL,
            ADDR_MCYCLE, ADDR_MCYCLEH,
            ADDR_MINSTRET, ADDR_MINSTRETH: wmask = MASK_FULL;
            default:      wmask = MASK_NONE;
        endcase
    end

    always_comb begin
        case (csr_req_i.op)
            CSR_SET:   wr_data_o = (cur_val | csr_req_i.wdata) & wmask;
            CSR_CLEAR: wr_data_o = (cur_val & ~csr_req_i.wdata) & wmask;
            default:   wr_data_o = csr_req_i.wdata & wmask;     // Plain write
        endcase
    end

    //////////////////////////////////////////////////////////////////////
    // Write selects and local registers
    //////////////////////////////////////////////////////////////////////

    always_comb begin
        wsel_o = '0;
        if (write_ok) begin
            case (csr_req_i.addr)
                ADDR_MSTATUS:   wsel_o.mstatus     = 1'b1;
                ADDR_MEPC:      wsel_o.mepc        = 1'b1;
                ADDR_MCAUSE:    wsel_o.mcause      = 1'b1;
                ADDR_MTVAL:     wsel_o.mtval       = 1'b1;
                ADDR_MCYCLE:    wsel_o.mcycle_lo   = 1'b1;
                ADDR_MCYCLEH:   wsel_o.mcycle_hi   = 1'b1;
                ADDR_MINSTRET:  wsel_o.minstret_lo = 1'b1;
                ADDR_MINSTRETH: wsel_o.minstret_hi = 1'b1;
                default:        ;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            mtvec_q <= MTVEC_RESET;
            mie_q   <= '0;
        end else if (write_ok) begin
            if (csr_req_i.addr == ADDR_MTVEC)
                mtvec_q <= wr_data_o;
            if (csr_req_i.addr == ADDR_MIE)
                mie_q <= wr_data_o;
        end
    end

    always_ff @(posedge clk) begin
        if (write_ok && csr_req_i.addr == ADDR_MSCRATCH)
            mscratch_q <= wr_data_o;
    end

    assign mie_o   = mie_q;
    assign mtvec_o = mtvec_q;

endmodule

`default_nettype wire

//--- hdl/csr_trap_unit.sv
/*
 * Trap state: mstatus, mepc, mcause, mtval and privilege level,
 * updated by mret, exception and interrupt entry, and CSR writes
 */
`default_nettype none

module csr_trap_unit
    import csr_pkg::*;
(
    input  logic        clk,
    input  logic        reset,
    input  trap_req_t   trap_i,
    input  logic        irq_ack_i,
    input  irq_code_e   irq_code_i,
    input  xlen_t       wr_data_i,
    input  csr_wsel_t   wsel_i,
    output trap_state_t state_o,
    output logic        mstatus_mie_o,
    output priv_e       privilege_o
);

    xlen_t mstatus_q;
    xlen_t mepc_q;
    xlen_t mcause_q;
    xlen_t mtval_q;
    priv_e priv_q;

    always_ff @(posedge clk) begin
        if (reset) begin
            mstatus_q <= MSTATUS_RESET;
            mepc_q    <= '0;
            mcause_q  <= '0;
            mtval_q   <= '0;
            priv_q    <= PRIV_M;
        end else if (trap_i.machine_return) begin
            mstatus_q[MSTATUS_MIE_BIT] <= mstatus_q[MSTATUS_MPIE_BIT];
            priv_q <= priv_e'(mstatus_q[MSTATUS_MPP_LO +: 2]);    // Back to MPP
        end else if (trap_i.raise_exception) begin
            mcause_q <= {27'b0, trap_i.exc_code};
            mepc_q   <= trap_i.pc;
            if (trap_i.exc_code == EXC_ILLEGAL_INSTR)
                mtval_q <= trap_i.instruction;                    // Faulting word
            else
                mtval_q <= trap_i.pc;
            mstatus_q[MSTATUS_MPIE_BIT]      <= mstatus_q[MSTATUS_MIE_BIT];
            mstatus_q[MSTATUS_MIE_BIT]       <= 1'b0;
            mstatus_q[MSTATUS_MPP_LO +: 2]   <= priv_q;
            priv_q <= PRIV_M;
        end else if (irq_ack_i) begin
            mcause_q <= {1'b1, 26'b0, irq_code_i};                // Interrupt flag in bit 31
            // Resume at the branch target when the interrupted op was a taken jump
            mepc_q   <= trap_i.jump ? trap_i.jump_target : trap_i.pc;
            mstatus_q[MSTATUS_MPIE_BIT]      <= mstatus_q[MSTATUS_MIE_BIT];
            mstatus_q[MSTATUS_MIE_BIT]       <= 1'b0;
            mstatus_q[MSTATUS_MPP_LO +: 2]   <= priv_q;
            priv_q <= PRIV_M;
        end else begin
            if (wsel_i.mstatus)
                mstatus_q <= wr_data_i;     // Already masked
            if (wsel_i.mepc)
                mepc_q <= wr_data_i;
            if (wsel_i.mcause)
                mcause_q <= wr_data_i;
            if (wsel_i.mtval)
                mtval_q <= wr_data_i;
        end
    end

    assign state_o.mstatus = mstatus_q;
    assign state_o.mepc    = mepc_q;
    assign state_o.mcause  = mcause_q;
    assign state_o.mtval   = mtval_q;

    assign mstatus_mie_o = mstatus_q[MSTATUS_MIE_BIT];
    assign privilege_o   = priv_q;

endmodule

`default_nettype wire

//--- hdl/csr_irq_ctrl.sv
/*
 * Interrupt control: mip sampling, registered pending flag
 * and priority selection of the interrupt cause
 */
`default_nettype none

module csr_irq_ctrl
    import csr_pkg::*;
(
    input  logic      clk,
    input  logic      reset,
    input  xlen_t     irq_i,
    input  xlen_t     mie_i,
    input  logic      mstatus_mie_i,
    input  logic      irq_ack_i,
    output xlen_t     mip_o,
    output logic      pending_o,
    output irq_code_e irq_code_o
);

    xlen_t     mip_q;
    logic      take_irq;
    irq_code_e code_q;

    always_ff @(posedge clk) begin
        if (reset)
            mip_q <= '0;
        else
            mip_q <= irq_i;
    end

    // Globally enabled, some enabled line pending, not being acknowledged
    assign take_irq = mstatus_mie_i && ((mie_i & mip_q) != '0) && !irq_ack_i;

    always_ff @(posedge clk) begin
        if (reset)
            pending_o <= 1'b0;
        else
            pending_o <= take_irq;
    end

    // External first, then software, then timer
    always_ff @(posedge clk) begin
        if (take_irq) begin
            if (mip_q[MEI_BIT] & mie_i[MEI_BIT])
                code_q <= IRQ_M_EXT;
            else if (mip_q[MSI_BIT] & mie_i[MSI_BIT])
                code_q <= IRQ_M_SW;
            else if (mip_q[MTI_BIT] & mie_i[MTI_BIT])
                code_q <= IRQ_M_TIM;
        end
    end

    assign mip_o      = mip_q;
    assign irq_code_o = code_q;

endmodule

`default_nettype wire

//--- hdl/csr_counters.sv
/*
 * mcycle and minstret 64-bit counters with half-word writes
 */
`default_nettype none

module csr_counters
    import csr_pkg::*;
(
    input  logic        clk,
    input  logic        reset,
    input  logic        killed_i,
    input  xlen_t       wr_data_i,
    input  csr_wsel_t   wsel_i,
    output logic [63:0] mcycle_o,
    output logic [63:0] minstret_o
);

    // A write to one half replaces that half and holds the other
    function automatic logic [63:0] next_count(input logic [63:0] cnt, input logic inc,
                                               input logic wr_lo, input logic wr_hi,
                                               input xlen_t data);
        if (wr_lo)
            return {cnt[63:32], data};
        else if (wr_hi)
            return {data, cnt[31:0]};
        else
            return cnt + {63'b0, inc};
    endfunction

    always_ff @(posedge clk) begin
        if (reset) begin
            mcycle_o   <= '0;
            minstret_o <= '0;
        end else begin
            mcycle_o   <= next_count(mcycle_o, 1'b1, wsel_i.mcycle_lo,
                                     wsel_i.mcycle_hi, wr_data_i);
            minstret_o <= next_count(minstret_o, ~killed_i, wsel_i.minstret_lo,
                                     wsel_i.minstret_hi, wr_data_i);    // Retired only
        end
    end

endmodule

`default_nettype wire

//--- hdl/csr_bank.sv
/*
 * Machine-mode CSR bank top level, connects access, trap,
 * interrupt and counter units
 */
`default_nettype none

module csr_bank
    import csr_pkg::*;
(
    input  logic      clk,
    input  logic      reset,
    input  csr_req_t  csr_req_i,
    input  logic      killed_i,
    input  trap_req_t trap_i,
    input  xlen_t     irq_i,
    input  logic      interrupt_ack_i,
    output xlen_t     csr_rdata_o,
    output logic      interrupt_pending_o,
    output priv_e     privilege_o,
    output xlen_t     mepc_o,
    output xlen_t     mtvec_o
);

    xlen_t       wr_data;
    csr_wsel_t   wsel;
    trap_state_t trap_state;
    xlen_t       mie;
    xlen_t       mip;
    logic        mstatus_mie;
    irq_code_e   irq_code;
    logic [63:0] mcycle;
    logic [63:0] minstret;

    csr_access u_access (
        .clk          (clk),
        .reset        (reset),
        .csr_req_i    (csr_req_i),
        .killed_i     (killed_i),
        .trap_state_i (trap_state),
        .mip_i        (mip),
        .mcycle_i     (mcycle),
        .minstret_i   (minstret),
        .wr_data_o    (wr_data),
        .wsel_o       (wsel),
        .mie_o        (mie),
        .mtvec_o      (mtvec_o),
        .rdata_o      (csr_rdata_o)
    );

    csr_trap_unit u_trap (
        .clk           (clk),
        .reset         (reset),
        .trap_i        (trap_i),
        .irq_ack_i     (interrupt_ack_i),
        .irq_code_i    (irq_code),
        .wr_data_i     (wr_data),
        .wsel_i        (wsel),
        .state_o       (trap_state),
        .mstatus_mie_o (mstatus_mie),
        .privilege_o   (privilege_o)
    );

    csr_irq_ctrl u_irq (
        .clk           (clk),
        .reset         (reset),
        .irq_i         (irq_i),
        .mie_i         (mie),
        .mstatus_mie_i (mstatus_mie),
        .irq_ack_i     (interrupt_ack_i),
        .mip_o         (mip),
        .pending_o     (interrupt_pending_o),
        .irq_code_o    (irq_code)
    );

    csr_counters u_counters (
        .clk        (clk),
        .reset      (reset),
        .killed_i   (killed_i),
        .wr_data_i  (wr_data),
        .wsel_i     (wsel),
        .mcycle_o   (mcycle),
        .minstret_o (minstret)
    );

    assign mepc_o = trap_state.mepc;    // Return address to fetch

endmodule

`default_nettype wire

//--- testbench/csr_bank_sva.sv
/*
 * Concurrent assertions on the CSR bank ports, bound to csr_bank
 */
`default_nettype none

module csr_bank_sva
    import csr_pkg::*;
(
    input logic     clk,
    input logic     reset,
    input csr_req_t csr_req_i,
    input logic     interrupt_ack_i,
    input xlen_t    csr_rdata_o,
    input logic     interrupt_pending_o,
    input priv_e    privilege_o
);

    int fail_count = 0;     // Failed assertions so far

    // Read port idles at zero
    rdata_zero_idle: assert property (@(posedge clk) disable iff (reset)
        !csr_req_i.read_en |-> csr_rdata_o == '0)
    else begin
        $error("Read data is not zero while no read is enabled");
        fail_count++;
    end

    pending_drops_after_ack: assert property (@(posedge clk) disable iff (reset)
        interrupt_ack_i |=> !interrupt_pending_o)
    else begin
        $error("Interrupt pending still high the cycle after an acknowledge");
        fail_count++;
    end

    machine_after_reset: assert property (@(posedge clk)
        reset |=> privilege_o == PRIV_M)
    else begin
        $error("Privilege is not machine mode after reset");
        fail_count++;
    end

endmodule

bind csr_bank csr_bank_sva u_csr_bank_sva (
    .clk                 (clk),
    .reset               (reset),
    .csr_req_i           (csr_req_i),
    .interrupt_ack_i     (interrupt_ack_i),
    .csr_rdata_o         (csr_rdata_o),
    .interrupt_pending_o (interrupt_pending_o),
    .privilege_o         (privilege_o)
);

`default_nettype wire

//--- testbench/tb_csr_bank.sv
/*
 * Testbench for the CSR bank: clock, reset, stimulus tasks,
 * reference model of the writable registers, checks and watchdog
 */
`default_nettype none

module tb_csr_bank
    import csr_pkg::*;
();

    localparam int CLK_PERIOD     = 40;
    localparam int RESET_CYCLES   = 16;
    localparam int DRIVE_DELAY    = 2;
    localparam int TIMEOUT_CYCLES = 400;   // All tests need well under half of this

    localparam int IDX_MSCRATCH = 0;
    localparam int IDX_MTVEC    = 1;
    localparam int IDX_MIE      = 2;
    localparam int IDX_MSTATUS  = 3;

    localparam csr_addr_t REG_ADDR [4] = '{ADDR_MSCRATCH, ADDR_MTVEC, ADDR_MIE, ADDR_MSTATUS};
    localparam xlen_t     REG_MASK [4] = '{MASK_FULL, MASK_MTVEC, MASK_MIE, MASK_MSTATUS};
    localparam csr_op_e   OPS [3]      = '{CSR_WRITE, CSR_SET, CSR_CLEAR};
    localparam exc_code_e EXC_CODES [2] = '{EXC_ILLEGAL_INSTR, EXC_ECALL_M};

    logic      clk;
    logic      reset;
    csr_req_t  csr_req;
    logic      killed;
    trap_req_t trap_req;
    xlen_t     irq;
    logic      irq_ack;
    xlen_t     csr_rdata;
    logic      interrupt_pending;
    priv_e     privilege;
    xlen_t     mepc;
    xlen_t     mtvec;

    int    seed = 54710;
    int    errors = 0;
    int    checks = 0;
    int    sva_errors;
    int    cycles;
    xlen_t model [4];          // Expected mscratch, mtvec, mie, mstatus
    priv_e priv_m;
    xlen_t rdata;
    xlen_t data;
    xlen_t pc;
    xlen_t instr;
    xlen_t count_a;
    xlen_t count_b;

    csr_bank u_csr_bank (
        .clk                 (clk),
        .reset               (reset),
        .csr_req_i           (csr_req),
        .killed_i            (killed),
        .trap_i              (trap_req),
        .irq_i               (irq),
        .interrupt_ack_i     (irq_ack),
        .csr_rdata_o         (csr_rdata),
        .interrupt_pending_o (interrupt_pending),
        .privilege_o         (privilege),
        .mepc_o              (mepc),
        .mtvec_o             (mtvec)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    //////////////////////////////////////////////////////////////////////
    // Reference rules
    //////////////////////////////////////////////////////////////////////

    function automatic xlen_t masked_result(input csr_op_e op, input xlen_t cur,
                                            input xlen_t wdata, input xlen_t mask);
        case (op)
            CSR_SET:   return (cur | wdata) & mask;
            CSR_CLEAR: return (cur & ~wdata) & mask;
            default:   return wdata & mask;
        endcase
    endfunction

    // mstatus after any trap entry
    function automatic xlen_t trap_mstatus(input xlen_t ms, input priv_e prev);
        xlen_t r;
        r = ms;
        r[MSTATUS_MPIE_BIT]     = ms[MSTATUS_MIE_BIT];
        r[MSTATUS_MIE_BIT]      = 1'b0;
        r[MSTATUS_MPP_LO +: 2]  = prev;
        return r;
    endfunction

    task automatic check_value(input string name, input xlen_t expected, input xlen_t actual);
        checks++;
        assert (actual === expected)
        else begin
            $display("Mismatch %s: expected %h, actual %h", name, expected, actual);
            errors++;
        end
    endtask

    //////////////////////////////////////////////////////////////////////
    // Stimulus tasks
    //////////////////////////////////////////////////////////////////////

    task automatic drive_idle(input logic kill);
        csr_req    = '0;
        csr_req.op = CSR_WRITE;
        trap_req   = '0;
        irq_ack    = 1'b0;
        killed     = kill;
    endtask

    task automatic idle_cycles(input int n, input logic kill);
        repeat (n) begin
            @(posedge clk);
            #DRIVE_DELAY;
            drive_idle(kill);
        end
    endtask

    // One access cycle, read data sampled mid cycle
    task automatic csr_cycle(input logic rd, input logic wr, input csr_op_e op,
                             input csr_addr_t addr, input xlen_t wdata, input logic kill,
                             output xlen_t result);
        @(posedge clk);
        #DRIVE_DELAY;
        drive_idle(kill);
        csr_req.read_en  = rd;
        csr_req.write_en = wr;
        csr_req.op       = op;
        csr_req.addr     = addr;
        csr_req.wdata    = wdata;
        @(negedge clk);
        result = csr_rdata;
    endtask

    task automatic csr_write(input csr_op_e op, input csr_addr_t addr, input xlen_t wdata);
        xlen_t unused;
        csr_cycle(1'b0, 1'b1, op, addr, wdata, 1'b0, unused);
    endtask

    task automatic csr_read(input csr_addr_t addr, output xlen_t result);
        csr_cycle(1'b1, 1'b0, CSR_WRITE, addr, '0, 1'b0, result);
    endtask

    task automatic write_modelled(input int idx, input csr_op_e op, input xlen_t wdata);
        csr_write(op, REG_ADDR[idx], wdata);
        model[idx] = masked_result(op, model[idx], wdata, REG_MASK[idx]);
    endtask

    task automatic raise_exception(input exc_code_e code, input xlen_t epc, input xlen_t word);
        @(posedge clk);
        #DRIVE_DELAY;
        drive_idle(1'b0);
        trap_req.raise_exception = 1'b1;
        trap_req.exc_code        = code;
        trap_req.pc              = epc;
        trap_req.instruction     = word;
        idle_cycles(1, 1'b0);
    endtask

    task automatic return_from_trap();
        @(posedge clk);
        #DRIVE_DELAY;
        drive_idle(1'b0);
        trap_req.machine_return = 1'b1;
        idle_cycles(1, 1'b0);
    endtask

    task automatic acknowledge_irq(input xlen_t epc, input xlen_t target);
        @(posedge clk);
        #DRIVE_DELAY;
        drive_idle(1'b0);
        irq_ack              = 1'b1;
        trap_req.pc          = epc;
        trap_req.jump        = 1'b1;
        trap_req.jump_target = target;
        idle_cycles(1, 1'b0);
    endtask

    //////////////////////////////////////////////////////////////////////
    // Test sequence
    //////////////////////////////////////////////////////////////////////

    initial begin
        drive_idle(1'b0);
        irq   = '0;
        reset = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        #DRIVE_DELAY;
        reset = 1'b0;
        model[IDX_MTVEC]   = MTVEC_RESET;
        model[IDX_MIE]     = '0;
        model[IDX_MSTATUS] = MSTATUS_RESET;
        priv_m = PRIV_M;
        check_value("reset_mepc", '0, mepc);
        check_value("reset_mtvec", MTVEC_RESET, mtvec);
        check_value("reset_priv", xlen_t'(PRIV_M), xlen_t'(privilege));

        // Masked write, set and clear; mscratch starts with a plain write
        for (int round = 0; round < 2; round++) begin
            for (int r = 0; r < 4; r++) begin
                for (int o = 0; o < 3; o++) begin
                    data = $random(seed);
                    write_modelled(r, OPS[o], data);
                    csr_read(REG_ADDR[r], rdata);
                    check_value("masked_op", model[r], rdata);
                end
            end
        end
        check_value("mtvec_port", model[IDX_MTVEC], mtvec);
        csr_read(ADDR_MISA, rdata);
        check_value("misa_read", MISA_VALUE, rdata);
        csr_write(CSR_WRITE, ADDR_MISA, $random(seed));
        csr_read(ADDR_MISA, rdata);
        check_value("misa_write_ignored", MISA_VALUE, rdata);
        csr_read(ADDR_MHARTID, rdata);
        check_value("mhartid_zero", '0, rdata);

        // Killed write and killed read
        csr_cycle(1'b0, 1'b1, CSR_WRITE, ADDR_MSCRATCH, $random(seed), 1'b1, rdata);
        csr_read(ADDR_MSCRATCH, rdata);
        check_value("killed_write", model[IDX_MSCRATCH], rdata);
        csr_cycle(1'b1, 1'b0, CSR_WRITE, ADDR_MSCRATCH, '0, 1'b1, rdata);
        check_value("killed_read", '0, rdata);

        // Drop to user mode so the first exception also changes privilege
        write_modelled(IDX_MSTATUS, CSR_WRITE, '0);
        return_from_trap();
        priv_m = PRIV_U;

        // Illegal instruction, then ecall, each with MIE set
        for (int e = 0; e < 2; e++) begin
            write_modelled(IDX_MSTATUS, CSR_SET, xlen_t'(1) << MSTATUS_MIE_BIT);
            pc    = $random(seed);
            instr = $random(seed);
            raise_exception(EXC_CODES[e], pc, instr);
            model[IDX_MSTATUS] = trap_mstatus(model[IDX_MSTATUS], priv_m);
            priv_m = PRIV_M;
            check_value("exc_mepc", pc, mepc);
            csr_read(ADDR_MCAUSE, rdata);
            check_value("exc_mcause", xlen_t'(EXC_CODES[e]), rdata);
            csr_read(ADDR_MTVAL, rdata);
            check_value("exc_mtval", (EXC_CODES[e] == EXC_ILLEGAL_INSTR) ? instr : pc, rdata);
            csr_read(ADDR_MSTATUS, rdata);
            check_value("exc_mstatus", model[IDX_MSTATUS], rdata);
            check_value("exc_priv", xlen_t'(priv_m), xlen_t'(privilege));
        end

        // mret into user mode, MPP zero and MPIE set
        write_modelled(IDX_MSTATUS, CSR_WRITE, xlen_t'(1) << MSTATUS_MPIE_BIT);
        return_from_trap();
        model[IDX_MSTATUS][MSTATUS_MIE_BIT] = model[IDX_MSTATUS][MSTATUS_MPIE_BIT];
        priv_m = priv_e'(model[IDX_MSTATUS][MSTATUS_MPP_LO +: 2]);
        check_value("mret_priv", xlen_t'(PRIV_U), xlen_t'(privilege));
        csr_read(ADDR_MSTATUS, rdata);
        check_value("mret_mstatus", model[IDX_MSTATUS], rdata);

        // External and timer lines together
        write_modelled(IDX_MIE, CSR_WRITE, (xlen_t'(1) << MEI_BIT) | (xlen_t'(1) << MTI_BIT));
        write_modelled(IDX_MSTATUS, CSR_SET, xlen_t'(1) << MSTATUS_MIE_BIT);
        @(posedge clk);
        #DRIVE_DELAY;
        drive_idle(1'b0);
        irq = (xlen_t'(1) << MEI_BIT) | (xlen_t'(1) << MTI_BIT);
        cycles = 0;
        @(negedge clk);
        while (!interrupt_pending && cycles < 8) begin
            @(negedge clk);
            cycles++;
        end
        checks++;
        assert (interrupt_pending && cycles <= 2)
        else begin
            $display("Interrupt pending flag did not rise within two cycles of the request");
            errors++;
        end
        pc   = $random(seed);
        data = $random(seed);
        acknowledge_irq(pc, data);
        irq = '0;
        model[IDX_MSTATUS] = trap_mstatus(model[IDX_MSTATUS], priv_m);
        priv_m = PRIV_M;
        check_value("irq_mepc", data, mepc);
        csr_read(ADDR_MCAUSE, rdata);
        check_value("irq_mcause", 32'h8000_000B, rdata);
        csr_read(ADDR_MSTATUS, rdata);
        check_value("irq_mstatus", model[IDX_MSTATUS], rdata);
        check_value("irq_priv", xlen_t'(priv_m), xlen_t'(privilege));

        // Ten edges between the two mcycle samples
        csr_read(ADDR_MCYCLE, count_a);
        idle_cycles(9, 1'b0);
        csr_read(ADDR_CYCLE, count_b);
        check_value("mcycle_delta", 32'd10, count_b - count_a);

        // Nine edges, five of them after killed cycles
        csr_read(ADDR_MINSTRET, count_a);
        idle_cycles(5, 1'b1);
        idle_cycles(3, 1'b0);
        csr_read(ADDR_INSTRET, count_b);
        check_value("minstret_delta", 32'd9 - 32'd5, count_b - count_a);

        data = $random(seed);
        csr_write(CSR_WRITE, ADDR_MINSTRETH, data);
        csr_read(ADDR_MINSTRETH, rdata);
        check_value("minstreth_write", data, rdata);

        idle_cycles(2, 1'b0);
        sva_errors = u_csr_bank.u_csr_bank_sva.fail_count;
        $display("Checks: %0d, check errors: %0d, assertion errors: %0d",
                 checks, errors, sva_errors);
        if (errors == 0 && sva_errors == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

    // Watchdog
    initial begin
        #(TIMEOUT_CYCLES * CLK_PERIOD);
        $display("Timeout: the tests did not finish within %0d clock cycles", TIMEOUT_CYCLES);
        $display("Errors found");
        $finish;
    end

endmodule

`default_nettype wire

//--- all.f
hdl/csr_pkg.sv
hdl/csr_access.sv
hdl/csr_trap_unit.sv
hdl/csr_irq_ctrl.sv
hdl/csr_counters.sv
hdl/csr_bank.sv
testbench/csr_bank_sva.sv
testbench/tb_csr_bank.sv

//--- Bender.yml
package:
  name: csr_bank

sources:
  - files:
      - hdl/csr_pkg.sv
      - hdl/csr_access.sv
      - hdl/csr_trap_unit.sv
      - hdl/csr_irq_ctrl.sv
      - hdl/csr_counters.sv
      - hdl/csr_bank.sv
  - target: test
    files:
      - testbench/csr_bank_sva.sv
      - testbench/tb_csr_bank.sv
